//--- sdInitPkg.sv
// SD card initialization shared definitions
// Frame lengths, card clock ratio, command indices and arguments,
// response kinds and the sequencer step encoding
package sdInitPkg;

    // ========================================
    // Timing and frame sizes
    // ========================================
    // clk cycles per card clock period, must be even
    localparam int ClkDivRatio  = 30;
    localparam int CmdLen       = 48;
    localparam int ShortRespLen = 48;
    localparam int LongRespLen  = 136;
    // N_CC / N_RC spacing and the trailing clocks before done
    localparam int GapTicks     = 8;

    // ========================================
    // Command indices
    // ========================================
    localparam logic [5:0] CmdGoIdle      = 6'd0;
    localparam logic [5:0] CmdAllSendCid  = 6'd2;
    localparam logic [5:0] CmdSendRca     = 6'd3;
    localparam logic [5:0] CmdSetBusWidth = 6'd6;
    localparam logic [5:0] CmdSelect      = 6'd7;
    localparam logic [5:0] CmdIfCond      = 6'd8;
    localparam logic [5:0] CmdSendOpCond  = 6'd41;
    localparam logic [5:0] CmdAppCmd      = 6'd55;

    // Command arguments
    // 2.7-3.6 V supply, check pattern 0xAA
    localparam logic [31:0] ArgIfCond    = 32'h0000_01AA;
    // HCS and XPC set, S18R clear, 2.7-2.8 V window
    localparam logic [31:0] ArgOpCond    = 32'h5000_8000;
    // Bus width code 2 selects four data lines
    localparam logic [31:0] ArgBusWidth4 = 32'h0000_0002;

    // What the deserializer should expect after a command
    typedef enum logic [1:0] {
        RespNone,
        RespShortCrc,
        RespShortNoCrc,
        RespLong
    } respKindT;

    // Sequencer steps, issue steps first
    typedef enum logic [7:0] {
        SeqGoIdle, SeqIfCond, SeqAppOp, SeqOpCond, SeqCid,
        SeqRca, SeqSelect, SeqAppBus, SeqBusWidth,
        SeqSend, SeqResp, SeqGap, SeqDone, SeqHalt
    } seqStateT;

endpackage

//--- crc7.sv
// Serial CRC7 generator
// Polynomial x^7 + x^3 + 1, one bit per enabled cycle,
// shared by the command and response paths
`timescale 1ns/1ps

module crc7 (
    input  logic       clk,
    input  logic       rstDone2,
    input  logic       clear,
    input  logic       bitEn,
    input  logic       bitIn,
    output logic [6:0] crc
);

    logic feedback;

    // Incoming bit against the register MSB
    assign feedback = bitIn ^ crc[6];

    always_ff @(posedge clk) begin
        if (!rstDone2 || clear) begin
            crc <= '0;
        end else if (bitEn) begin
            // Tap at x^3, feedback into x^0
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

//--- sdClockGen.sv
// Card clock generator
// Divides clk by ClkDivRatio into sdClk and marks each edge with a
// one-cycle tick; clkStop parks the clock low with no ticks
`timescale 1ns/1ps

module sdClockGen import sdInitPkg::*; (
    input  logic clk,
    input  logic rstDone2,
    input  logic clkStop,
    output logic sdClk,
    output logic fallTick,
    output logic riseTick
);

    logic [$clog2(ClkDivRatio)-1:0] divCnt;

    always_ff @(posedge clk) begin
        if (!rstDone2 || clkStop) begin
            // Held low with the counter parked
            divCnt   <= '0;
            sdClk    <= 1'b0;
            fallTick <= 1'b0;
            riseTick <= 1'b0;
        end else begin
            fallTick <= 1'b0;
            riseTick <= 1'b0;
            if (divCnt == ClkDivRatio / 2 - 1) begin
                // Half point, rising edge
                sdClk    <= 1'b1;
                riseTick <= 1'b1;
                divCnt   <= divCnt + 1'b1;
            end else if (divCnt == ClkDivRatio - 1) begin
                // End of period, falling edge
                sdClk    <= 1'b0;
                fallTick <= 1'b1;
                divCnt   <= '0;
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

endmodule

//--- cmdSerializer.sv
// Command serializer
// Takes one command per credit, shifts the 48-bit frame onto CMD on
// the falling card clock edge and inserts the CRC7 after bit 8,
// then returns the credit
`timescale 1ns/1ps

module cmdSerializer import sdInitPkg::*; (
    input  logic        clk,
    input  logic        rstDone2,
    input  logic        fallTick,
    input  logic        cmdValid,
    input  logic [5:0]  cmdIndex,
    input  logic [31:0] cmdArg,
    output logic        cmdOut,
    output logic        cmdOutEn,
    output logic        cmdCredit
);

    logic [CmdLen-1:0]          frame;
    logic [$clog2(CmdLen+1)-1:0] sent;
    logic                       busy;
    logic [6:0]                 crcVal;

    // CRC runs over start, transmission, index and argument
    crc7 u_crc (
        .clk      (clk),
        .rstDone2 (rstDone2),
        .clear    (cmdValid),
        .bitEn    (fallTick && busy && sent < CmdLen - 8),
        .bitIn    (frame[CmdLen-1]),
        .crc      (crcVal)
    );

    // Frame shift register
    always_ff @(posedge clk) begin
        if (cmdValid) begin
            // CRC slot zero for now, end bit set
            frame <= {1'b0, 1'b1, cmdIndex, cmdArg, 7'b0, 1'b1};
        end else if (fallTick && busy) begin
            if (sent == CmdLen - 8) begin
                // CRC6 goes out now, the rest follows with the end bit
                frame <= {crcVal[5:0], 1'b1, {(CmdLen-7){1'b0}}};
            end else begin
                frame <= frame << 1;
            end
        end
    end

    // Line control and credit return
    always_ff @(posedge clk) begin
        if (!rstDone2) begin
            busy      <= 1'b0;
            sent      <= '0;
            cmdOut    <= 1'b1;
            cmdOutEn  <= 1'b0;
            cmdCredit <= 1'b0;
        end else begin
            cmdCredit <= 1'b0;
            if (cmdValid) begin
                busy <= 1'b1;
                sent <= '0;
            end else if (fallTick && busy) begin
                if (sent == CmdLen) begin
                    // End bit has had its full bit time
                    busy      <= 1'b0;
                    cmdOut    <= 1'b1;
                    cmdOutEn  <= 1'b0;
                    cmdCredit <= 1'b1;
                end else begin
                    cmdOut   <= (sent == CmdLen - 8) ? crcVal[6] : frame[CmdLen-1];
                    cmdOutEn <= 1'b1;
                    sent     <= sent + 1'b1;
                end
            end
        end
    end

endmodule

//--- respDeserializer.sv
// Response deserializer
// Arms when a command ends, hunts for the start bit on CMD, shifts in a
// 48- or 136-bit response on the rising card clock edge and checks
// transmission bit, CRC7 or all-ones fields, and end bit
`timescale 1ns/1ps

module respDeserializer import sdInitPkg::*; (
    input  logic                   clk,
    input  logic                   rstDone2,
    input  logic                   riseTick,
    input  logic                   cmdIn,
    input  logic                   cmdCredit,
    input  respKindT               respKind,
    output logic                   respValid,
    output logic                   respErr,
    output logic                   respLong,
    output logic [LongRespLen-1:0] respBits
);

    logic [1:0]             cmdSync;
    logic                   hunting;
    logic                   receiving;
    respKindT               kindReg;
    logic [7:0]             bitIdx;
    logic [7:0]             covTop;
    logic                   sampleTake;
    logic [LongRespLen-1:0] assembled;
    logic [6:0]             crcVal;
    logic                   frameBad;

    // Two-flop synchronizer, idle line reads high
    always_ff @(posedge clk) begin
        if (!rstDone2) begin
            cmdSync <= 2'b11;
        end else begin
            cmdSync <= {cmdSync[0], cmdIn};
        end
    end

    // A low sample while hunting is the start bit and is kept
    assign sampleTake = riseTick && (receiving || (hunting && !cmdSync[1]));
    assign assembled  = {respBits[LongRespLen-2:0], cmdSync[1]};

    // Highest bit covered by CRC, R2 skips start, transmission and reserved
    assign covTop = (kindReg == RespLong) ? 8'(LongRespLen - 9) : 8'(ShortRespLen - 1);

    crc7 u_crc (
        .clk      (clk),
        .rstDone2 (rstDone2),
        .clear    (cmdCredit),
        .bitEn    (sampleTake && bitIdx <= covTop && bitIdx >= 8'd8),
        .bitIn    (cmdSync[1]),
        .crc      (crcVal)
    );

    // Framing checks on the complete frame including the end bit
    always_comb begin
        frameBad = !assembled[0];
        if (kindReg == RespLong) begin
            frameBad = frameBad || assembled[LongRespLen-2] || (assembled[7:1] != crcVal);
        end else if (kindReg == RespShortCrc) begin
            frameBad = frameBad || assembled[ShortRespLen-2] || (assembled[7:1] != crcVal);
        end else begin
            // R3 carries ones in place of index and CRC
            frameBad = frameBad || assembled[ShortRespLen-2]
                       || (assembled[45:40] != 6'h3F) || (assembled[7:1] != 7'h7F);
        end
    end

    // Receive payload
    always_ff @(posedge clk) begin
        if (cmdCredit) begin
            respBits <= '0;
        end else if (sampleTake) begin
            respBits <= assembled;
        end
    end

    // Arm, hunt, receive, report
    always_ff @(posedge clk) begin
        if (!rstDone2) begin
            hunting   <= 1'b0;
            receiving <= 1'b0;
            kindReg   <= RespNone;
            bitIdx    <= '0;
            respValid <= 1'b0;
            respErr   <= 1'b0;
            respLong  <= 1'b0;
        end else begin
            respValid <= 1'b0;
            if (cmdCredit && respKind != RespNone) begin
                hunting <= 1'b1;
                kindReg <= respKind;
                bitIdx  <= (respKind == RespLong) ? 8'(LongRespLen - 1)
                                                  : 8'(ShortRespLen - 1);
            end else if (sampleTake) begin
                hunting   <= 1'b0;
                receiving <= 1'b1;
                bitIdx    <= bitIdx - 1'b1;
                if (bitIdx == 8'd0) begin
                    // End bit just sampled
                    receiving <= 1'b0;
                    respValid <= 1'b1;
                    respErr   <= frameBad;
                    respLong  <= (kindReg == RespLong);
                end
            end
        end
    end

endmodule

//--- initSequencer.sv
// Initialization sequencer
// Walks CMD0, CMD8, ACMD41 with busy retry, CMD2, CMD3, CMD7 and ACMD6,
// spaces commands by GapTicks card clocks, decodes responses and
// ends by stopping the card clock and raising done, or halts on error
`timescale 1ns/1ps

module initSequencer import sdInitPkg::*; (
    input  logic                   clk,
    input  logic                   rstDone2,
    input  logic                   fallTick,
    input  logic                   cmdCredit,
    input  logic                   respValid,
    input  logic                   respErr,
    input  logic [LongRespLen-1:0] respBits,
    output logic                   cmdValid,
    output logic [5:0]             cmdIndex,
    output logic [31:0]            cmdArg,
    output respKindT               respKind,
    output logic                   clkStop,
    output logic [15:0]            rca,
    output logic                   done,
    output logic                   err
);

    seqStateT                      state;
    seqStateT                      nextStep;
    seqStateT                      afterStep;
    logic                          credit;
    logic [$clog2(GapTicks)-1:0]   gapCnt;
    logic                          isIssue;
    logic [5:0]                    issueIdx;
    logic [31:0]                   issueArg;
    respKindT                      issueKind;

    // ========================================
    // Command table
    // ========================================
    always_comb begin
        isIssue   = 1'b1;
        issueIdx  = CmdGoIdle;
        issueArg  = '0;
        issueKind = RespNone;
        afterStep = SeqIfCond;
        case (state)
            SeqIfCond: begin
                issueIdx  = CmdIfCond;
                issueArg  = ArgIfCond;
                issueKind = RespShortCrc;
                afterStep = SeqAppOp;
            end
            SeqAppOp: begin
                issueIdx  = CmdAppCmd;
                issueArg  = {rca, 16'h0};
                issueKind = RespShortCrc;
                afterStep = SeqOpCond;
            end
            SeqOpCond: begin
                issueIdx  = CmdSendOpCond;
                issueArg  = ArgOpCond;
                issueKind = RespShortNoCrc;
                afterStep = SeqCid;
            end
            SeqCid: begin
                issueIdx  = CmdAllSendCid;
                issueKind = RespLong;
                afterStep = SeqRca;
            end
            SeqRca: begin
                issueIdx  = CmdSendRca;
                issueKind = RespShortCrc;
                afterStep = SeqSelect;
            end
            SeqSelect: begin
                issueIdx  = CmdSelect;
                issueArg  = {rca, 16'h0};
                issueKind = RespShortCrc;
                afterStep = SeqAppBus;
            end
            SeqAppBus: begin
                issueIdx  = CmdAppCmd;
                issueArg  = {rca, 16'h0};
                issueKind = RespShortCrc;
                afterStep = SeqBusWidth;
            end
            SeqBusWidth: begin
                issueIdx  = CmdSetBusWidth;
                issueArg  = ArgBusWidth4;
                issueKind = RespShortCrc;
                afterStep = SeqDone;
            end
            SeqGoIdle: ;
            default: isIssue = 1'b0;
        endcase
    end

    // Clock stop and done rise together
    assign clkStop = (state == SeqDone);
    assign done    = (state == SeqDone);
    // Halt is terminal so err stays up
    assign err     = (state == SeqHalt);

    // Argument latched together with the command
    always_ff @(posedge clk) begin
        if (isIssue && credit) begin
            cmdArg <= issueArg;
        end
    end

    // ========================================
    // Step machine
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstDone2) begin
            state    <= SeqGoIdle;
            nextStep <= SeqIfCond;
            credit   <= 1'b1;
            cmdValid <= 1'b0;
            cmdIndex <= CmdGoIdle;
            respKind <= RespNone;
            gapCnt   <= '0;
            rca      <= '0;
        end else begin
            cmdValid <= 1'b0;
            if (cmdCredit) begin
                credit <= 1'b1;
            end
            case (state)
                SeqSend: begin
                    // Frame is out, wait for reply or space it
                    if (cmdCredit) begin
                        gapCnt <= '0;
                        state  <= (respKind == RespNone) ? SeqGap : SeqResp;
                    end
                end
                SeqResp: begin
                    if (respValid) begin
                        gapCnt <= '0;
                        state  <= SeqGap;
                        if (respErr) begin
                            state <= SeqHalt;
                        end else if (cmdIndex == CmdIfCond
                                     && respBits[15:8] != ArgIfCond[7:0]) begin
                            // Echoed check pattern mismatch
                            state <= SeqHalt;
                        end
                        // Card still busy, back to CMD55
                        if (cmdIndex == CmdSendOpCond && !respBits[39]) begin
                            nextStep <= SeqAppOp;
                        end
                        if (cmdIndex == CmdSendRca) begin
                            rca <= respBits[39:24];
                        end
                    end
                end
                SeqGap: begin
                    if (fallTick) begin
                        gapCnt <= gapCnt + 1'b1;
                        if (gapCnt == GapTicks - 1) begin
                            state <= nextStep;
                        end
                    end
                end
                SeqDone, SeqHalt: ;
                default: begin
                    // Issue step, needs the credit
                    if (isIssue && credit) begin
                        credit   <= 1'b0;
                        cmdValid <= 1'b1;
                        cmdIndex <= issueIdx;
                        respKind <= issueKind;
                        nextStep <= afterStep;
                        state    <= SeqSend;
                    end
                end
            endcase
        end
    end

endmodule

//--- sdCardInitializer.sv
// SD card initialization controller top
// Card clock generator, command sequencer, CMD serializer and
// response deserializer on one system clock
`timescale 1ns/1ps

module sdCardInitializer import sdInitPkg::*; (
    input  logic        clk,
    input  logic        rstDone2,
    input  logic        cmdIn,
    output logic        sdClk,
    output logic        cmdOut,
    output logic        cmdOutEn,
    output logic [15:0] rca,
    output logic        done,
    output logic        err
);

    logic                   fallTick;
    logic                   riseTick;
    logic                   clkStop;
    logic                   cmdValid;
    logic [5:0]             cmdIndex;
    logic [31:0]            cmdArg;
    respKindT               respKind;
    logic                   cmdCredit;
    logic                   respValid;
    logic                   respErr;
    logic [LongRespLen-1:0] respBits;

    sdClockGen u_clkGen (
        .clk      (clk),
        .rstDone2 (rstDone2),
        .clkStop  (clkStop),
        .sdClk    (sdClk),
        .fallTick (fallTick),
        .riseTick (riseTick)
    );

    initSequencer u_seq (
        .clk       (clk),
        .rstDone2  (rstDone2),
        .fallTick  (fallTick),
        .cmdCredit (cmdCredit),
        .respValid (respValid),
        .respErr   (respErr),
        .respBits  (respBits),
        .cmdValid  (cmdValid),
        .cmdIndex  (cmdIndex),
        .cmdArg    (cmdArg),
        .respKind  (respKind),
        .clkStop   (clkStop),
        .rca       (rca),
        .done      (done),
        .err       (err)
    );

    cmdSerializer u_cmdTx (
        .clk       (clk),
        .rstDone2  (rstDone2),
        .fallTick  (fallTick),
        .cmdValid  (cmdValid),
        .cmdIndex  (cmdIndex),
        .cmdArg    (cmdArg),
        .cmdOut    (cmdOut),
        .cmdOutEn  (cmdOutEn),
        .cmdCredit (cmdCredit)
    );

    // Sequencer reads response length from its own command step
    respDeserializer u_respRx (
        .clk       (clk),
        .rstDone2  (rstDone2),
        .riseTick  (riseTick),
        .cmdIn     (cmdIn),
        .cmdCredit (cmdCredit),
        .respKind  (respKind),
        .respValid (respValid),
        .respErr   (respErr),
        .respLong  (),
        .respBits  (respBits)
    );

endmodule

//--- tbSdCardModel.sv
// Behavioral SD card on the CMD line
// Collects each command on the rising card clock edge, checks its
// framing and CRC7, and answers on the falling edge with R1, R2, R3,
// R6 or R7; busy count, RCA and two faults are set from outside
`timescale 1ns/1ps

module tbSdCardModel import sdInitPkg::*; (
    input  logic        rstDone2,
    input  logic        sdClk,
    input  logic        cmdOut,
    input  logic        cmdOutEn,
    input  logic [3:0]  busyCount,
    input  logic [15:0] rcaVal,
    input  logic        badRcaCrc,
    input  logic        badEcho,
    output logic        cmdIn,
    output logic        newCmd,
    output logic        frameOk,
    output logic [5:0]  lastIdx,
    output logic [31:0] lastArg,
    output logic [7:0]  cmdCount,
    output logic [15:0] gapRises,
    output logic        driving,
    output logic        rcaPublished,
    output logic [3:0]  opCondCount
);

    // Card identification register, CRC is appended at send time
    localparam logic [119:0] CidValue = 120'h0353_4453_4431_3647_8012_3456_7801_3A;

    logic [47:0]  frame;
    logic [135:0] resp;
    logic [15:0]  idleRises;
    logic         ready;
    int           i;

    // Bitwise CRC7, divisor 0x09 shifted in from the top
    function automatic logic [6:0] crcOf(input logic [127:0] data, input int nBits);
        logic [6:0] crc;
        logic       msb;
        int         k;
        crc = 7'h00;
        for (k = nBits - 1; k >= 0; k--) begin
            msb = crc[6] ^ data[k];
            crc = {crc[5:0], 1'b0};
            if (msb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    // 48-bit response with index, payload and CRC, optionally spoiled
    function automatic logic [135:0] shortFrame(input logic [5:0] idx,
                                                input logic [31:0] payload,
                                                input logic corrupt);
        logic [39:0] head;
        logic [6:0]  crc;
        head = {2'b00, idx, payload};
        crc  = crcOf(head, 40) ^ {6'b0, corrupt};
        return {88'h0, head, crc, 1'b1};
    endfunction

    // Drive len bits MSB first, one per falling edge, then release
    task automatic sendResponse(input logic [135:0] bits, input int len);
        int b;
        for (b = len - 1; b >= 0; b--) begin
            @(negedge sdClk);
            #1;
            cmdIn   = bits[b];
            driving = 1'b1;
        end
        // Host samples the end bit here
        @(posedge sdClk);
        idleRises = '0;
        @(negedge sdClk);
        #1;
        cmdIn   = 1'b1;
        driving = 1'b0;
    endtask

    task automatic clearState();
        cmdIn        = 1'b1;
        newCmd       = 1'b0;
        frameOk      = 1'b1;
        lastIdx      = '0;
        lastArg      = '0;
        cmdCount     = '0;
        gapRises     = '0;
        idleRises    = '0;
        driving      = 1'b0;
        rcaPublished = 1'b0;
        opCondCount  = '0;
    endtask

    // ========================================
    // Command receive and answer loop
    // ========================================
    initial begin
        clearState();
        forever begin
            @(posedge sdClk or negedge rstDone2);
            if (!rstDone2) begin
                clearState();
            end else if (cmdOutEn) begin
                // Host takes the line, remember the idle stretch before it
                gapRises  = idleRises;
                frame[47] = cmdOut;
                for (i = 46; i >= 0; i--) begin
                    @(posedge sdClk);
                    frame[i] = cmdOut;
                end
                frameOk   = !frame[47] && frame[46] && frame[0]
                            && (frame[7:1] == crcOf(frame[47:8], 40));
                lastIdx   = frame[45:40];
                lastArg   = frame[39:8];
                cmdCount  = cmdCount + 1'b1;
                newCmd    = 1'b1;
                idleRises = '0;
                // First falling edge after the end bit, N_CR is two clocks
                @(negedge sdClk);
                newCmd = 1'b0;
                case (lastIdx)
                    CmdIfCond: begin
                        // R7 echoes voltage and check pattern
                        resp = shortFrame(lastIdx,
                                          {lastArg[31:8], badEcho ? 8'h55 : lastArg[7:0]},
                                          1'b0);
                        sendResponse(resp, ShortRespLen);
                    end
                    CmdAppCmd: begin
                        sendResponse(shortFrame(lastIdx, 32'h0000_0120, 1'b0), ShortRespLen);
                    end
                    CmdSendOpCond: begin
                        // R3, busy bit low until the retry budget is spent
                        opCondCount = opCondCount + 1'b1;
                        ready       = (opCondCount > busyCount);
                        resp        = '0;
                        resp[47:0]  = {2'b00, 6'h3F, ready, 1'b1, 6'h00, 24'hFF_8000,
                                       7'h7F, 1'b1};
                        sendResponse(resp, ShortRespLen);
                    end
                    CmdAllSendCid: begin
                        resp = {2'b00, 6'h3F, CidValue, crcOf(CidValue, 120), 1'b1};
                        sendResponse(resp, LongRespLen);
                    end
                    CmdSendRca: begin
                        resp = shortFrame(lastIdx, {rcaVal, 16'h0500}, badRcaCrc);
                        sendResponse(resp, ShortRespLen);
                        rcaPublished = 1'b1;
                    end
                    CmdSelect: begin
                        sendResponse(shortFrame(lastIdx, 32'h0000_0700, 1'b0), ShortRespLen);
                    end
                    CmdSetBusWidth: begin
                        sendResponse(shortFrame(lastIdx, 32'h0000_0920, 1'b0), ShortRespLen);
                    end
                    // CMD0 and anything unknown get no answer
                    default: ;
                endcase
            end else begin
                idleRises = idleRises + 1'b1;
            end
        end
    end

endmodule

//--- tbSdInit.sv
// Testbench for the SD card initialization controller
// Four runs against the card model: clean, ACMD41 retry, bad CMD3
// response CRC and wrong CMD8 echo; concurrent assertions check
// framing, order, gaps, arguments and the final outcome
`timescale 1ns/1ps

module tbSdInit import sdInitPkg::*; ();

    // Whole session is about a quarter of this
    localparam int TimeoutCycles = 400000;

    logic        clk;
    logic        rstDone2;
    logic        cmdIn;
    logic        sdClk;
    logic        cmdOut;
    logic        cmdOutEn;
    logic [15:0] rca;
    logic        done;
    logic        err;

    // Card knobs and expected outcome of the current run
    logic [3:0]  busyKnob;
    logic [15:0] rcaKnob;
    logic        badCrcKnob;
    logic        badEchoKnob;
    logic        expectDone;

    // Card observations
    logic        newCmd;
    logic        frameOk;
    logic [5:0]  lastIdx;
    logic [31:0] lastArg;
    logic [7:0]  cmdCount;
    logic [15:0] gapRises;
    logic        driving;
    logic        rcaPublished;
    logic [3:0]  opCondCount;

    int          errorCount;
    int          testCount;
    int          passCount;
    int          cycleCount;
    integer      seed;

    sdCardInitializer u_dut (
        .clk      (clk),
        .rstDone2 (rstDone2),
        .cmdIn    (cmdIn),
        .sdClk    (sdClk),
        .cmdOut   (cmdOut),
        .cmdOutEn (cmdOutEn),
        .rca      (rca),
        .done     (done),
        .err      (err)
    );

    tbSdCardModel u_card (
        .rstDone2     (rstDone2),
        .sdClk        (sdClk),
        .cmdOut       (cmdOut),
        .cmdOutEn     (cmdOutEn),
        .busyCount    (busyKnob),
        .rcaVal       (rcaKnob),
        .badRcaCrc    (badCrcKnob),
        .badEcho      (badEchoKnob),
        .cmdIn        (cmdIn),
        .newCmd       (newCmd),
        .frameOk      (frameOk),
        .lastIdx      (lastIdx),
        .lastArg      (lastArg),
        .cmdCount     (cmdCount),
        .gapRises     (gapRises),
        .driving      (driving),
        .rcaPublished (rcaPublished),
        .opCondCount  (opCondCount)
    );

    always #50 clk = ~clk;

    // Whole-session watchdog
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic flagError(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        errorCount++;
    endtask

    // Command index at position pos of the start-up list
    function automatic logic [5:0] expectedIndex(input int pos, input int busy);
        int loopEnd;
        loopEnd = 2 + 2 * (busy + 1);
        if (pos == 0) return CmdGoIdle;
        if (pos == 1) return CmdIfCond;
        // CMD55 and CMD41 alternate for every attempt
        if (pos < loopEnd) return (pos % 2 == 0) ? CmdAppCmd : CmdSendOpCond;
        case (pos - loopEnd)
            0: return CmdAllSendCid;
            1: return CmdSendRca;
            2: return CmdSelect;
            3: return CmdAppCmd;
            4: return CmdSetBusWidth;
            default: return 6'h3F;
        endcase
    endfunction

    // ========================================
    // Checks
    // ========================================
    assert property (@(posedge clk) disable iff (!rstDone2) $rose(newCmd) |-> frameOk)
        else flagError("command frame with bad start, transmission, CRC or end bit");
    assert property (@(posedge clk) disable iff (!rstDone2)
        $rose(newCmd) |-> lastIdx == expectedIndex(int'(cmdCount) - 1, busyKnob))
        else flagError("command index out of order");
    assert property (@(posedge clk) disable iff (!rstDone2)
        $rose(newCmd) && lastIdx == CmdSelect |-> lastArg[31:16] == rcaKnob)
        else flagError("CMD7 argument does not carry the RCA");
    assert property (@(posedge clk) disable iff (!rstDone2)
        $rose(newCmd) && lastIdx == CmdAppCmd
        |-> lastArg[31:16] == (rcaPublished ? rcaKnob : 16'h0))
        else flagError("CMD55 argument has the wrong RCA field");
    assert property (@(posedge clk) disable iff (!rstDone2)
        $rose(newCmd) && cmdCount > 1 |-> gapRises >= GapTicks)
        else flagError("fewer than GapTicks card clocks before a command");
    // Host and card never drive CMD together
    assert property (@(posedge clk) disable iff (!rstDone2) !(driving && cmdOutEn))
        else flagError("host drives CMD during a response");
    assert property (@(posedge clk) disable iff (!rstDone2)
        $rose(newCmd) |-> !(badCrcKnob && lastIdx == CmdSelect))
        else flagError("CMD7 sent after a bad CMD3 response");
    assert property (@(posedge clk) disable iff (!rstDone2)
        $rose(newCmd) |-> !(badEchoKnob && lastIdx == CmdAppCmd))
        else flagError("CMD55 sent after a wrong CMD8 echo");
    assert property (@(posedge clk) disable iff (!rstDone2) !(expectDone && err))
        else flagError("err raised in a run that should finish");
    assert property (@(posedge clk) disable iff (!rstDone2) !(!expectDone && done))
        else flagError("done raised in a run that should fail");
    assert property (@(posedge clk) disable iff (!rstDone2)
        $rose(done) |-> rca == rcaKnob && opCondCount == busyKnob + 1'b1)
        else flagError("rca or ACMD41 attempt count wrong at done");
    // Card clock parked after done
    assert property (@(posedge clk) disable iff (!rstDone2) done |=> !sdClk)
        else flagError("sdClk running after done");

    // Reset, set the card up, run to done or err, then report
    task automatic runTest(input string name, input int busy, input logic badCrc,
                           input logic badEchoIn, input logic wantDone);
        int errBefore;
        errBefore = errorCount;
        @(posedge clk);
        #1;
        rstDone2    = 1'b0;
        busyKnob    = busy[3:0];
        rcaKnob     = 16'($random(seed));
        badCrcKnob  = badCrc;
        badEchoKnob = badEchoIn;
        expectDone  = wantDone;
        repeat (16) @(posedge clk);
        #1;
        rstDone2 = 1'b1;
        while (!done && !err) begin
            @(posedge clk);
        end
        // Let a late wrong command or outcome show up
        repeat (200) @(posedge clk);
        testCount++;
        if (errorCount == errBefore) begin
            passCount++;
            $display("test %-16s pass", name);
        end else begin
            $display("test %-16s FAIL, %0d check(s) failed", name, errorCount - errBefore);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rstDone2    = 1'b0;
        busyKnob    = '0;
        rcaKnob     = '0;
        badCrcKnob  = 1'b0;
        badEchoKnob = 1'b0;
        expectDone  = 1'b0;
        errorCount  = 0;
        testCount   = 0;
        passCount   = 0;
        cycleCount  = 0;
        seed        = 32'hb72d;
        runTest("clean", 0, 1'b0, 1'b0, 1'b1);
        runTest("acmd41 retry", 3, 1'b0, 1'b0, 1'b1);
        runTest("bad cmd3 crc", 0, 1'b1, 1'b0, 1'b0);
        runTest("wrong cmd8 echo", 0, 1'b0, 1'b1, 1'b0);
        $display("tests run %0d, passed %0d, failed checks %0d",
                 testCount, passCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sources.f
sdInitPkg.sv
crc7.sv
sdClockGen.sv
cmdSerializer.sv
respDeserializer.sv
initSequencer.sv
sdCardInitializer.sv
tbSdCardModel.sv
tbSdInit.sv
